/* Makefile */
TOP := tb_xpoint_switch

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* filelist.f */
src/xpoint_pkg.sv
src/cfg_frame_fsm.sv
src/cfg_word_counter.sv
src/select_reg_bank.sv
src/lane_crosspoint.sv
src/xpoint_switch_top.sv
tests/tb_xpoint_switch.sv

/* src/cfg_frame_fsm.sv */
// Config frame receive FSM
`timescale 1ns/100ps

module cfg_frame_fsm (
    input  logic        clk,
    input  logic        rst,

    // Parsed frame header
    input  logic        hdr_valid,
    input  logic [15:0] eth_type,
    output logic        hdr_ready,

    // Frame payload
    input  logic        payload_valid,
    input  logic        payload_last,
    output logic        payload_ready,

    // Word counter
    input  logic        last_word,
    output logic        cnt_clear,
    output logic        cnt_step,

    // Select bank
    output logic        sel_write
);
    import xpoint_pkg::*;

    logic [STATE_W-1:0] state;
    logic               hdr_xfer;
    logic               beat_xfer;

    assign hdr_xfer  = hdr_valid & hdr_ready;
    assign beat_xfer = payload_valid & payload_ready;

    // Only non-last beats in LOAD carry select bytes
    assign sel_write = (state == ST_LOAD) && beat_xfer && !payload_last;
    assign cnt_step  = sel_write;

    // Word index restarts with every accepted header
    assign cnt_clear = hdr_xfer;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            hdr_ready     <= 1'b0;
            payload_ready <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    hdr_ready <= 1'b1;
                    if (hdr_xfer) begin
                        hdr_ready     <= 1'b0;
                        payload_ready <= 1'b1;
                        if (eth_type == CFG_ETHERTYPE) begin
                            state <= ST_LOAD;
                        end else begin
                            state <= ST_DISCARD;
                        end
                    end
                end

                ST_LOAD, ST_DISCARD: begin
                    if (beat_xfer) begin
                        if (payload_last) begin
                            // End of frame, take the next header
                            state         <= ST_IDLE;
                            payload_ready <= 1'b0;
                            hdr_ready     <= 1'b1;
                        end else if (state == ST_LOAD && last_word) begin
                            // All select words stored, drop the rest
                            state <= ST_DISCARD;
                        end
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Header and payload sides are never open at once
    a_ready_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(hdr_ready && payload_ready)
    );

endmodule

/* src/cfg_word_counter.sv */
// Config word counter
`timescale 1ns/100ps

module cfg_word_counter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             clear,
    input  logic                             step,
    output logic [xpoint_pkg::CFG_IDX_W-1:0] word_idx,
    output logic                             last_word
);
    import xpoint_pkg::*;

    localparam logic [CFG_IDX_W-1:0] LAST_IDX = CFG_IDX_W'(CFG_WORDS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            word_idx <= '0;
        end else if (clear) begin
            word_idx <= '0;
        end else if (step) begin
            // Wraps after the final word, the FSM has left LOAD by then
            word_idx <= word_idx + 1'b1;
        end
    end

    // Final stored word of a frame
    assign last_word = (word_idx == LAST_IDX);

endmodule

/* src/lane_crosspoint.sv */
// Registered lane crosspoint
`timescale 1ns/100ps

module lane_crosspoint (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_DATA_W-1:0] rxd,
    input  logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_CTRL_W-1:0] rxc,
    input  logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::SEL_W-1:0]       sel,
    output logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_DATA_W-1:0] txd,
    output logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_CTRL_W-1:0] txc
);
    import xpoint_pkg::*;

    logic [NUM_PORTS-1:0][LANE_DATA_W-1:0] next_txd;
    logic [NUM_PORTS-1:0][LANE_CTRL_W-1:0] next_txc;

    // One mux per output, idle unless the select names a real input
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            next_txd[i] = IDLE_DATA;
            next_txc[i] = IDLE_CTRL;
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (sel[i] == SEL_W'(j)) begin
                    next_txd[i] = rxd[j];
                    next_txc[i] = rxc[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                txd[i] <= IDLE_DATA;
                txc[i] <= IDLE_CTRL;
            end
        end else begin
            txd <= next_txd;
            txc <= next_txc;
        end
    end

    // Out-of-range select shows up as idle one cycle later
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_idle_chk
        a_idle_fill: assert property (
            @(posedge clk) disable iff (rst)
            (sel[g] >= NUM_PORTS) |=> (txd[g] == IDLE_DATA && txc[g] == IDLE_CTRL)
        );
    end

endmodule

/* src/select_reg_bank.sv */
// Output select registers
`timescale 1ns/100ps

module select_reg_bank (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  write,
    input  logic [xpoint_pkg::CFG_IDX_W-1:0]      word_idx,
    input  xpoint_pkg::cfg_word_u                 word,
    output logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::SEL_W-1:0] sel
);
    import xpoint_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Output i takes input i out of reset
            for (int i = 0; i < NUM_PORTS; i++) begin
                sel[i] <= SEL_W'(i);
            end
        end else if (write) begin
            // A payload word covers one group of SELS_PER_WORD outputs
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (CFG_IDX_W'(i / SELS_PER_WORD) == word_idx) begin
                    sel[i] <= word.sel[i % SELS_PER_WORD];
                end
            end
        end
    end

endmodule

/* src/xpoint_pkg.sv */
// Lane crosspoint shared definitions
package xpoint_pkg;

    // Lane geometry
    localparam int NUM_PORTS   = 16;
    localparam int LANE_DATA_W = 64;
    localparam int LANE_CTRL_W = 8;

    // Select registers and config frame layout
    localparam int SEL_W         = 8;
    localparam int SELS_PER_WORD = 8;
    localparam int CFG_WORDS     = 2;
    localparam int CFG_IDX_W     = 1;

    localparam logic [15:0] CFG_ETHERTYPE = 16'h8099;

    // XGMII idle, 0x07 in every byte lane with all control bits set
    localparam logic [LANE_DATA_W-1:0] IDLE_DATA = {(LANE_DATA_W / 8){8'h07}};
    localparam logic [LANE_CTRL_W-1:0] IDLE_CTRL = '1;

    // Config FSM state encodings
    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] ST_IDLE    = 2'd0;
    localparam logic [STATE_W-1:0] ST_LOAD    = 2'd1;
    localparam logic [STATE_W-1:0] ST_DISCARD = 2'd2;

    // Payload word, either raw data or eight select bytes
    // Byte 0 sits in bits 7:0 and feeds the lowest output of the word
    typedef union packed {
        logic [LANE_DATA_W-1:0]              raw;
        logic [SELS_PER_WORD-1:0][SEL_W-1:0] sel;
    } cfg_word_u;

endpackage

/* src/xpoint_switch_top.sv */
// Lane crosspoint switch top
`timescale 1ns/100ps

module xpoint_switch_top (
    input  logic                                                          clk,
    input  logic                                                          rst,

    // XGMII lanes
    input  logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_DATA_W-1:0] lane_rxd,
    input  logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_CTRL_W-1:0] lane_rxc,
    output logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_DATA_W-1:0] lane_txd,
    output logic [xpoint_pkg::NUM_PORTS-1:0][xpoint_pkg::LANE_CTRL_W-1:0] lane_txc,

    // Config frame header
    input  logic                                                          cfg_hdr_valid,
    input  logic [15:0]                                                   cfg_eth_type,
    output logic                                                          cfg_hdr_ready,

    // Config frame payload
    input  logic [xpoint_pkg::LANE_DATA_W-1:0]                            cfg_payload_data,
    input  logic                                                          cfg_payload_valid,
    input  logic                                                          cfg_payload_last,
    output logic                                                          cfg_payload_ready
);
    import xpoint_pkg::*;

    logic                              cnt_clear;
    logic                              cnt_step;
    logic [CFG_IDX_W-1:0]              word_idx;
    logic                              last_word;
    logic                              sel_write;
    logic [NUM_PORTS-1:0][SEL_W-1:0]   sel;
    cfg_word_u                         cfg_word;

    // Same payload bits, viewed as select bytes
    assign cfg_word = cfg_word_u'(cfg_payload_data);

    cfg_frame_fsm i_fsm (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (cfg_hdr_valid),
        .eth_type      (cfg_eth_type),
        .hdr_ready     (cfg_hdr_ready),
        .payload_valid (cfg_payload_valid),
        .payload_last  (cfg_payload_last),
        .payload_ready (cfg_payload_ready),
        .last_word     (last_word),
        .cnt_clear     (cnt_clear),
        .cnt_step      (cnt_step),
        .sel_write     (sel_write)
    );

    cfg_word_counter i_counter (
        .clk       (clk),
        .rst       (rst),
        .clear     (cnt_clear),
        .step      (cnt_step),
        .word_idx  (word_idx),
        .last_word (last_word)
    );

    select_reg_bank i_sel_bank (
        .clk      (clk),
        .rst      (rst),
        .write    (sel_write),
        .word_idx (word_idx),
        .word     (cfg_word),
        .sel      (sel)
    );

    lane_crosspoint i_xpoint (
        .clk (clk),
        .rst (rst),
        .rxd (lane_rxd),
        .rxc (lane_rxc),
        .sel (sel),
        .txd (lane_txd),
        .txc (lane_txc)
    );

endmodule

/* tests/tb_xpoint_switch.sv */
// Lane crosspoint switch testbench
`timescale 1ns/100ps

module tb_xpoint_switch;
    import xpoint_pkg::*;

    localparam int MAX_CYCLES  = 3000;
    localparam int HS_LIMIT    = 64;
    localparam int RAND_FRAMES = 150;

    logic                                  clk;
    logic                                  rst;
    logic [NUM_PORTS-1:0][LANE_DATA_W-1:0] lane_rxd;
    logic [NUM_PORTS-1:0][LANE_CTRL_W-1:0] lane_rxc;
    logic [NUM_PORTS-1:0][LANE_DATA_W-1:0] lane_txd;
    logic [NUM_PORTS-1:0][LANE_CTRL_W-1:0] lane_txc;
    logic                                  cfg_hdr_valid;
    logic [15:0]                           cfg_eth_type;
    logic                                  cfg_hdr_ready;
    logic [LANE_DATA_W-1:0]                cfg_payload_data;
    logic                                  cfg_payload_valid;
    logic                                  cfg_payload_last;
    logic                                  cfg_payload_ready;

    // Expected mapping, follows the frames sent so far
    logic [NUM_PORTS-1:0][SEL_W-1:0]       shadow_sel;

    // Lane inputs, mapping and reset as held just before the last edge
    logic [NUM_PORTS-1:0][LANE_DATA_W-1:0] prev_rxd;
    logic [NUM_PORTS-1:0][LANE_CTRL_W-1:0] prev_rxc;
    logic [NUM_PORTS-1:0][SEL_W-1:0]       prev_sel;
    logic                                  prev_rst;
    logic                                  prev_valid = 1'b0;

    logic [31:0]                           lane_rng;
    logic [31:0]                           cfg_rng;
    int                                    cycle_count = 0;
    logic [LANE_DATA_W-1:0]                beat_q[$];

    xpoint_switch_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .lane_rxd          (lane_rxd),
        .lane_rxc          (lane_rxc),
        .lane_txd          (lane_txd),
        .lane_txc          (lane_txc),
        .cfg_hdr_valid     (cfg_hdr_valid),
        .cfg_eth_type      (cfg_eth_type),
        .cfg_hdr_ready     (cfg_hdr_ready),
        .cfg_payload_data  (cfg_payload_data),
        .cfg_payload_valid (cfg_payload_valid),
        .cfg_payload_last  (cfg_payload_last),
        .cfg_payload_ready (cfg_payload_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random value in 0 to n-1 for config stimulus
    function automatic int cfg_rand(input int n);
        cfg_rng = lcg_step(cfg_rng);
        return int'(cfg_rng[31:16]) % n;
    endfunction

    // Expected {txd, txc} of one output for a given select
    function automatic logic [LANE_DATA_W+LANE_CTRL_W-1:0] route(
        input logic [NUM_PORTS-1:0][LANE_DATA_W-1:0] rxd,
        input logic [NUM_PORTS-1:0][LANE_CTRL_W-1:0] rxc,
        input logic [SEL_W-1:0]                      sel_val
    );
        int idx;
        idx = int'(sel_val);
        if (sel_val >= SEL_W'(NUM_PORTS)) begin
            return {IDLE_DATA, IDLE_CTRL};
        end
        return {rxd[idx], rxc[idx]};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_txd(input int lane, input logic [LANE_DATA_W-1:0] expected,
                             input logic [LANE_DATA_W-1:0] got);
        if (got !== expected) begin
            abort_run($sformatf("Fail %0t: lane %0d expected txd %h got %h",
                                $time, lane, expected, got));
        end
    endtask

    task automatic check_txc(input int lane, input logic [LANE_CTRL_W-1:0] expected,
                             input logic [LANE_CTRL_W-1:0] got);
        if (got !== expected) begin
            abort_run($sformatf("Fail %0t: lane %0d expected txc %h got %h",
                                $time, lane, expected, got));
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic got);
        if (got !== expected) begin
            abort_run($sformatf("Fail %0t: %s expected %b got %b",
                                $time, name, expected, got));
        end
    endtask

    task automatic drive_lanes();
        logic [31:0] hi;
        logic [31:0] lo;
        for (int i = 0; i < NUM_PORTS; i++) begin
            lane_rng = lcg_step(lane_rng);
            hi = lane_rng;
            lane_rng = lcg_step(lane_rng);
            lo = lane_rng;
            lane_rng = lcg_step(lane_rng);
            lane_rxd[i] = {hi, lo};
            lane_rxc[i] = lane_rng[31:24];
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Ready is a registered level, so its value here holds until the next edge
    task automatic send_header(input logic [15:0] eth);
        int   waited;
        logic accepted;
        waited        = 0;
        cfg_eth_type  = eth;
        cfg_hdr_valid = 1'b1;
        do begin
            accepted = cfg_hdr_ready;
            @(posedge clk);
            #2;
            waited++;
            if (!accepted && waited > HS_LIMIT) begin
                abort_run("Header was never accepted, cfg_hdr_ready stayed low");
            end
        end while (!accepted);
        cfg_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [LANE_DATA_W-1:0] data, input logic last);
        int   waited;
        logic accepted;
        waited            = 0;
        cfg_payload_data  = data;
        cfg_payload_last  = last;
        cfg_payload_valid = 1'b1;
        do begin
            accepted = cfg_payload_ready;
            @(posedge clk);
            #2;
            waited++;
            if (!accepted && waited > HS_LIMIT) begin
                abort_run("Payload beat was never accepted, cfg_payload_ready stayed low");
            end
        end while (!accepted);
        cfg_payload_valid = 1'b0;
        cfg_payload_last  = 1'b0;
    endtask

    // Sends the queued beats as one frame and updates the expected mapping
    task automatic send_frame(input logic [15:0] eth, input int max_gap);
        cfg_word_u w;
        int        stored;
        int        gap;
        logic      last;
        stored = 0;
        send_header(eth);
        for (int b = 0; b < beat_q.size(); b++) begin
            if (max_gap > 0) begin
                gap = cfg_rand(max_gap + 1);
                wait_cycles(gap);
            end
            last = (b == beat_q.size() - 1);
            send_beat(beat_q[b], last);
            // First two non-last words of a config frame carry the selects
            if (eth == CFG_ETHERTYPE && !last && stored < CFG_WORDS) begin
                w.raw = beat_q[b];
                for (int k = 0; k < SELS_PER_WORD; k++) begin
                    shadow_sel[stored * SELS_PER_WORD + k] = w.sel[k];
                end
                stored++;
            end
        end
        beat_q.delete();
    endtask

    task automatic push_map_word(input logic [NUM_PORTS-1:0][SEL_W-1:0] map, input int group);
        cfg_word_u w;
        for (int k = 0; k < SELS_PER_WORD; k++) begin
            w.sel[k] = map[group * SELS_PER_WORD + k];
        end
        beat_q.push_back(w.raw);
    endtask

    task automatic push_random_word(input int sel_range);
        cfg_word_u w;
        for (int k = 0; k < SELS_PER_WORD; k++) begin
            w.sel[k] = SEL_W'(cfg_rand(sel_range));
        end
        beat_q.push_back(w.raw);
    endtask

    task automatic make_permutation(output logic [NUM_PORTS-1:0][SEL_W-1:0] map);
        int               j;
        logic [SEL_W-1:0] t;
        for (int i = 0; i < NUM_PORTS; i++) begin
            map[i] = SEL_W'(i);
        end
        for (int i = NUM_PORTS - 1; i > 0; i--) begin
            j      = cfg_rand(i + 1);
            t      = map[i];
            map[i] = map[j];
            map[j] = t;
        end
    endtask

    // Fresh lane data every cycle
    initial begin
        lane_rng = 32'd47;
        drive_lanes();
        forever begin
            @(posedge clk);
            #2;
            drive_lanes();
        end
    end

    always @(posedge clk) begin
        prev_rxd   <= lane_rxd;
        prev_rxc   <= lane_rxc;
        prev_sel   <= shadow_sel;
        prev_rst   <= rst;
        prev_valid <= 1'b1;
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin : compare_outputs
        logic [LANE_DATA_W+LANE_CTRL_W-1:0] exp_lane;
        if (prev_valid) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (prev_rst) begin
                    exp_lane = {IDLE_DATA, IDLE_CTRL};
                end else begin
                    exp_lane = route(prev_rxd, prev_rxc, prev_sel[i]);
                end
                check_txd(i, exp_lane[LANE_DATA_W+LANE_CTRL_W-1:LANE_CTRL_W], lane_txd[i]);
                check_txc(i, exp_lane[LANE_CTRL_W-1:0], lane_txc[i]);
            end
            if (prev_rst) begin
                check_ready("cfg_hdr_ready", 1'b0, cfg_hdr_ready);
                check_ready("cfg_payload_ready", 1'b0, cfg_payload_ready);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout, the run did not finish within %0d cycles",
                                MAX_CYCLES));
        end
    end

    initial begin
        logic [NUM_PORTS-1:0][SEL_W-1:0] new_map;
        logic [15:0]                     eth;
        int                              n_beats;
        rst               = 1'b1;
        cfg_hdr_valid     = 1'b0;
        cfg_eth_type      = '0;
        cfg_payload_data  = '0;
        cfg_payload_valid = 1'b0;
        cfg_payload_last  = 1'b0;
        cfg_rng           = 32'd47;
        for (int i = 0; i < NUM_PORTS; i++) begin
            shadow_sel[i] = SEL_W'(i);
        end

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // Identity mapping right after reset
        wait_cycles(1);
        check_ready("cfg_hdr_ready", 1'b1, cfg_hdr_ready);
        check_ready("cfg_payload_ready", 1'b0, cfg_payload_ready);
        wait_cycles(8);

        // Full frame with a random permutation, last beat would point all at lane 3
        make_permutation(new_map);
        push_map_word(new_map, 0);
        push_map_word(new_map, 1);
        beat_q.push_back({(LANE_DATA_W / 8){8'h03}});
        send_frame(CFG_ETHERTYPE, 0);
        wait_cycles(6);
        check_ready("cfg_hdr_ready", 1'b1, cfg_hdr_ready);

        // Two beats, only outputs 0 to 7 change
        make_permutation(new_map);
        push_map_word(new_map, 0);
        beat_q.push_back({(LANE_DATA_W / 8){8'h05}});
        send_frame(CFG_ETHERTYPE, 0);
        wait_cycles(6);

        // Even outputs out of range
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (i % 2 == 0) begin
                new_map[i] = SEL_W'(NUM_PORTS + i);
            end else begin
                new_map[i] = SEL_W'(NUM_PORTS - 1 - i);
            end
        end
        new_map[4] = 8'hFF;
        push_map_word(new_map, 0);
        push_map_word(new_map, 1);
        push_random_word(NUM_PORTS);
        send_frame(CFG_ETHERTYPE, 0);
        wait_cycles(6);

        // Other EtherTypes are consumed and dropped
        for (n_beats = 1; n_beats <= 5; n_beats += 2) begin
            repeat (n_beats) push_random_word(NUM_PORTS);
            send_frame(16'h0800, 0);
            wait_cycles(2);
        end

        // Mixed frames with valid gaps and idle time between frames
        for (int f = 0; f < RAND_FRAMES; f++) begin
            if (cfg_rand(2) == 0) begin
                eth = CFG_ETHERTYPE;
            end else begin
                eth = 16'h86DD;
            end
            n_beats = 1 + cfg_rand(5);
            repeat (n_beats) push_random_word(NUM_PORTS + 4);
            send_frame(eth, 2);
            wait_cycles(cfg_rand(4));
        end
        wait_cycles(4);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
